// ==== include/syn_settings.svh ====
// ==========================================================
// widths and depths of the synaptic weight store
// weights are 8.8 fixed point and only stored, never used
// the address is neuron id in the upper bits, axon id below
// ==========================================================

`ifndef SYN_SETTINGS_SVH
`define SYN_SETTINGS_SVH

// neuron id and axon id widths
`define SYN_NURN_BITS 8
`define SYN_AXON_BITS 8

// flat synapse address
`define SYN_ADDR_BITS (`SYN_NURN_BITS + `SYN_AXON_BITS)
`define SYN_MEM_DEPTH (1 << `SYN_ADDR_BITS)

// 8.8 fixed point weight
`define SYN_WEIGHT_BITS 16

// read-back queue, 512 entries
// deep enough for a second neuron's reads while the first
// has not started learning yet
`define SYN_FIFO_ADDR_BITS 9
`define SYN_FIFO_DEPTH (1 << `SYN_FIFO_ADDR_BITS)

`endif

// ==== src/queue_pkg.sv ====
// ==========================================================
// types of the weight read-back FIFO
// the level needs one bit more than the pointers to reach 512
// ==========================================================

`include "syn_settings.svh"

package queue_pkg;

	import synapse_pkg::*;

	// read and write pointers wrap at the depth
	typedef logic [`SYN_FIFO_ADDR_BITS-1:0] fifo_ptr_t;

	// fill level, 0 up to the full depth
	typedef logic [`SYN_FIFO_ADDR_BITS:0] fifo_level_t;

	// one queued read, weight and where it came from
	typedef struct packed {
		weight_t   weight;
		syn_addr_u addr;
	} fifo_entry_t;

endpackage

// ==== src/synapse_mem_top.sv ====
// ==========================================================
// synaptic weight store with its read-back queue
// addresses are flat: neuron id in the upper byte
// no back-pressure, overflow_o flags dropped reads
// ==========================================================

`timescale 1ns/1ns

`include "syn_settings.svh"

module synapse_mem_top
	import synapse_pkg::*;
(
	input  logic                          clk_i,
	input  logic                          rst_n_i,
	input  logic                          start_i,

	input  logic                          wr_en_i,
	input  logic [`SYN_ADDR_BITS-1:0]     wr_addr_i,
	input  logic [`SYN_WEIGHT_BITS-1:0]   wr_data_i,

	input  logic                          rd_en_i,
	input  logic [`SYN_ADDR_BITS-1:0]     rd_addr_i,
	output logic [`SYN_WEIGHT_BITS-1:0]   rd_data_o,

	input  logic                          pop_i,
	output logic [`SYN_WEIGHT_BITS-1:0]   pop_weight_o,
	output logic [`SYN_NURN_BITS-1:0]     pop_nurn_o,
	output logic [`SYN_AXON_BITS-1:0]     pop_axon_o,
	output logic                          pop_valid_o,

	output logic [`SYN_FIFO_ADDR_BITS:0]  fifo_level_o,
	output logic                          overflow_o
);

	syn_addr_u wr_addr;
	syn_addr_u rd_addr;

	weight_push_if push_bus ();
	weight_pop_if  pop_bus ();

	assign wr_addr.flat = wr_addr_i;
	assign rd_addr.flat = rd_addr_i;

	weight_store u_store (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.wr_en_i   (wr_en_i),
		.wr_addr_i (wr_addr),
		.wr_data_i (wr_data_i),
		.rd_en_i   (rd_en_i),
		.rd_addr_i (rd_addr),
		.rd_data_o (rd_data_o),
		.push      (push_bus)
	);

	weight_fifo u_fifo (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.start_i    (start_i),
		.push       (push_bus),
		.pop        (pop_bus),
		.level_o    (fifo_level_o),
		.overflow_o (overflow_o)
	);

	weight_drain u_drain (
		.clk_i    (clk_i),
		.rst_n_i  (rst_n_i),
		.pop_i    (pop_i),
		.pop      (pop_bus),
		.weight_o (pop_weight_o),
		.nurn_o   (pop_nurn_o),
		.axon_o   (pop_axon_o),
		.valid_o  (pop_valid_o)
	);

endmodule

// ==== src/synapse_pkg.sv ====
// ==========================================================
// synapse level types shared by the whole design
// the address word is read flat by the memory and as
// neuron and axon fields by the learning side
// ==========================================================

`include "syn_settings.svh"

package synapse_pkg;

	// ids of a neuron and of one of its axons
	typedef logic [`SYN_NURN_BITS-1:0] nurn_id_t;
	typedef logic [`SYN_AXON_BITS-1:0] axon_id_t;

	// stored weight, 8.8 fixed point
	typedef logic [`SYN_WEIGHT_BITS-1:0] weight_t;

	// field layout of a synapse address
	typedef struct packed {
		nurn_id_t nurn;
		axon_id_t axon;
	} syn_fields_t;

	// one address word, two decodings
	// flat is the memory index, field splits it for learning
	typedef union packed {
		logic [`SYN_ADDR_BITS-1:0] flat;
		syn_fields_t               field;
	} syn_addr_u;

endpackage

// ==== src/weight_drain.sv ====
// ==========================================================
// learning side of the read-back FIFO
// registers the head on an accepted pop and splits its
// address into neuron id and axon id
// valid_o is high one cycle per accepted pop
// ==========================================================

`timescale 1ns/1ns

module weight_drain
	import synapse_pkg::*;
(
	input  logic       clk_i,
	input  logic       rst_n_i,
	input  logic       pop_i,

	weight_pop_if.drain pop,

	output weight_t    weight_o,
	output nurn_id_t   nurn_o,
	output axon_id_t   axon_o,
	output logic       valid_o
);

	logic accept;

	assign pop.pop = pop_i;

	// a pop on an empty queue is ignored by the FIFO too
	assign accept = pop_i && !pop.empty;

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			valid_o <= 1'b0;
		end
		else
		begin
			valid_o <= accept;
		end
	end

	// field view of the address gives the two ids
	always_ff @(posedge clk_i)
	begin
		if (accept)
		begin
			weight_o <= pop.weight;
			nurn_o   <= pop.syn_addr.field.nurn;
			axon_o   <= pop.syn_addr.field.axon;
		end
	end

endmodule

// ==== src/weight_fifo.sv ====
// ==========================================================
// 512-entry synchronous FIFO for read-back weights
// a push while full is dropped and sets the sticky overflow
// start_i empties the queue and clears overflow; a push or
// pop at the same edge has no effect
// ==========================================================

`timescale 1ns/1ns

`include "syn_settings.svh"

module weight_fifo
	import synapse_pkg::*;
	import queue_pkg::*;
(
	input  logic        clk_i,
	input  logic        rst_n_i,
	input  logic        start_i,

	weight_push_if.fifo push,
	weight_pop_if.fifo  pop,

	output fifo_level_t level_o,
	output logic        overflow_o
);

	fifo_entry_t entry_mem [0:`SYN_FIFO_DEPTH-1];
	fifo_entry_t head;

	fifo_ptr_t   wr_ptr_q;
	fifo_ptr_t   rd_ptr_q;
	fifo_level_t level_q;
	logic        overflow_q;

	logic        full;
	logic        empty;
	logic        do_push;
	logic        do_pop;

	assign full  = (level_q == fifo_level_t'(`SYN_FIFO_DEPTH));
	assign empty = (level_q == '0);

	// accepted transfers, step start wins over both
	assign do_push = push.push && !full && !start_i;
	assign do_pop  = pop.pop && !empty && !start_i;

	always_ff @(posedge clk_i)
	begin
		if (do_push)
		begin
			entry_mem[wr_ptr_q] <= '{weight: push.weight, addr: push.syn_addr};
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			level_q  <= '0;
		end
		else if (start_i)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			level_q  <= '0;
		end
		else
		begin
			if (do_push)
			begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (do_pop)
			begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			// level moves only when one side acts alone
			if (do_push && !do_pop)
			begin
				level_q <= level_q + 1'b1;
			end
			else if (do_pop && !do_push)
			begin
				level_q <= level_q - 1'b1;
			end
		end
	end

	// sticky until the next step
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			overflow_q <= 1'b0;
		end
		else if (start_i)
		begin
			overflow_q <= 1'b0;
		end
		else if (push.push && full)
		begin
			overflow_q <= 1'b1;
		end
	end

	assign head = entry_mem[rd_ptr_q];

	assign push.full    = full;
	assign pop.empty    = empty;
	assign pop.weight   = head.weight;
	assign pop.syn_addr = head.addr;

	assign level_o    = level_q;
	assign overflow_o = overflow_q;

endmodule

// ==== src/weight_fifo_if.sv ====
// ==========================================================
// push and pop buses around the weight read-back FIFO
// no back-pressure on push: full is only informative
// pop data always shows the head entry
// ==========================================================

`timescale 1ns/1ns

// store to FIFO
interface weight_push_if
	import synapse_pkg::*;
();

	logic      push;
	weight_t   weight;
	syn_addr_u syn_addr;
	logic      full;

	modport store (
		output push,
		output weight,
		output syn_addr,
		input  full
	);

	modport fifo (
		input  push,
		input  weight,
		input  syn_addr,
		output full
	);

endinterface

// FIFO to drain
interface weight_pop_if
	import synapse_pkg::*;
();

	logic      pop;
	weight_t   weight;
	syn_addr_u syn_addr;
	logic      empty;

	modport drain (
		output pop,
		input  weight,
		input  syn_addr,
		input  empty
	);

	modport fifo (
		input  pop,
		output weight,
		output syn_addr,
		output empty
	);

endinterface

// ==== src/weight_store.sv ====
// ==========================================================
// 64K x 16 weight memory, one write and one read port
// read data comes through the registered address, so a later
// write to that address shows without a new read enable
// every read is pushed to the FIFO one cycle after its enable
// ==========================================================

`timescale 1ns/1ns

`include "syn_settings.svh"

module weight_store
	import synapse_pkg::*;
(
	input  logic      clk_i,
	input  logic      rst_n_i,

	// write port
	input  logic      wr_en_i,
	input  syn_addr_u wr_addr_i,
	input  weight_t   wr_data_i,

	// read port
	input  logic      rd_en_i,
	input  syn_addr_u rd_addr_i,
	output weight_t   rd_data_o,

	weight_push_if.store push
);

	// weight array, indexed by the flat address
	weight_t   weight_mem [0:`SYN_MEM_DEPTH-1];

	syn_addr_u rd_addr_q;
	logic      push_q;

	always_ff @(posedge clk_i)
	begin
		if (wr_en_i)
		begin
			weight_mem[wr_addr_i.flat] <= wr_data_i;
		end
	end

	// read address holds until the next read enable
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			rd_addr_q <= '0;
		end
		else if (rd_en_i)
		begin
			rd_addr_q <= rd_addr_i;
		end
	end

	// push strobe lags the read enable by one cycle
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			push_q <= 1'b0;
		end
		else
		begin
			push_q <= rd_en_i;
		end
	end

	assign rd_data_o = weight_mem[rd_addr_q.flat];

	// the FIFO samples the word seen before the push edge
	assign push.push     = push_q;
	assign push.weight   = rd_data_o;
	assign push.syn_addr = rd_addr_q;

endmodule

// ==== testbench/synapse_mem_assertions.sv ====
// ============================================================
// concurrent checks on the read-back FIFO, bound into
// every weight_fifo; fail_count is read by the testbench
// ============================================================

`timescale 1ns/1ns

`include "syn_settings.svh"

module synapse_mem_assertions
	import queue_pkg::*;
(
	input logic        clk_i,
	input logic        rst_n_i,
	input logic        start_i,
	input logic        push_i,
	input logic        full_i,
	input logic        empty_i,
	input fifo_level_t level_i,
	input logic        overflow_i
);

	int fail_count = 0;

	// a dropped push must show up as overflow
	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(push_i && full_i && !start_i) |=> overflow_i)
	else
	begin
		fail_count++;
		$error("push while full did not set overflow");
	end

	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		level_i <= `SYN_FIFO_DEPTH)
	else
	begin
		fail_count++;
		$error("FIFO level above its depth");
	end

	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		start_i |=> (level_i == '0))
	else
	begin
		fail_count++;
		$error("FIFO level not 0 after start");
	end

	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!(empty_i && full_i))
	else
	begin
		fail_count++;
		$error("FIFO empty and full at once");
	end

endmodule

bind weight_fifo synapse_mem_assertions u_assertions (
	.clk_i      (clk_i),
	.rst_n_i    (rst_n_i),
	.start_i    (start_i),
	.push_i     (push.push),
	.full_i     (full),
	.empty_i    (empty),
	.level_i    (level_q),
	.overflow_i (overflow_q)
);

// ==== testbench/tb_synapse_mem.sv ====
// ============================================================
// testbench for synapse_mem_top, run from the project root
// cases come from testbench/weight_cases.txt
// inputs change 2 ns after the rising edge, outputs are
// sampled at that point, after every edge has settled
// ============================================================

`timescale 1ns/1ns

`include "syn_settings.svh"

module tb_synapse_mem;

	logic                         clk_i;
	logic                         rst_n_i;
	logic                         start_i;
	logic                         wr_en_i;
	logic [`SYN_ADDR_BITS-1:0]    wr_addr_i;
	logic [`SYN_WEIGHT_BITS-1:0]  wr_data_i;
	logic                         rd_en_i;
	logic [`SYN_ADDR_BITS-1:0]    rd_addr_i;
	logic [`SYN_WEIGHT_BITS-1:0]  rd_data_o;
	logic                         pop_i;
	logic [`SYN_WEIGHT_BITS-1:0]  pop_weight_o;
	logic [`SYN_NURN_BITS-1:0]    pop_nurn_o;
	logic [`SYN_AXON_BITS-1:0]    pop_axon_o;
	logic                         pop_valid_o;
	logic [`SYN_FIFO_ADDR_BITS:0] fifo_level_o;
	logic                         overflow_o;

	// one entry per case line
	byte         case_op [$];
	logic [15:0] case_addr [$];
	logic [15:0] case_data [$];
	logic [15:0] case_exp [$];

	// memory model, and queue model holding {weight, address}
	logic [15:0] model_mem [int];
	logic [31:0] model_q [$];
	logic [15:0] last_rd_addr;

	integer seed;
	int     errors;
	int     checks;
	int     cycle_count;
	int     cycle_limit;
	int     total_errors;

	synapse_mem_top uut (.*);

	initial
	begin
		clk_i = 1'b0;
		forever
		begin
			#10 clk_i = ~clk_i;
		end
	end

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s is %h, expected %h",
				$time, name, actual, expected);
		end
	endtask

	function automatic logic [15:0] model_weight(input logic [15:0] addr);
		if (model_mem.exists(addr))
		begin
			return model_mem[addr];
		end
		return 'x;
	endfunction

	// the FIFO drops what arrives while it holds its full depth
	function automatic void model_push(input logic [15:0] addr);
		if (model_q.size() < `SYN_FIFO_DEPTH)
		begin
			model_q.push_back({model_weight(addr), addr});
		end
	endfunction

	task automatic load_cases();
		integer      fd;
		integer      ch;
		integer      n;
		logic [15:0] a;
		logic [15:0] d;
		logic [15:0] e;
		fd = $fopen("testbench/weight_cases.txt", "r");
		if (fd == 0)
		begin
			errors++;
			$display("could not open the case file testbench/weight_cases.txt");
		end
		else
		begin
			ch = $fgetc(fd);
			while (ch != -1)
			begin
				if (ch == "#")
				begin
					while (ch != -1 && ch != "\n")
					begin
						ch = $fgetc(fd);
					end
				end
				else if (ch != " " && ch != "\n" && ch != "\r" && ch != "\t")
				begin
					n = $fscanf(fd, "%h %h %h", a, d, e);
					if (n == 3)
					begin
						case_op.push_back(ch[7:0]);
						case_addr.push_back(a);
						case_data.push_back(d);
						case_exp.push_back(e);
					end
					else
					begin
						errors++;
						$display("case line for operation %c is incomplete", ch[7:0]);
					end
				end
				ch = $fgetc(fd);
			end
			$fclose(fd);
		end
	endtask

	task automatic write_weight(input logic [15:0] addr, input logic [15:0] data);
		wr_en_i   = 1'b1;
		wr_addr_i = addr;
		wr_data_i = data;
		@(posedge clk_i);
		#2;
		wr_en_i = 1'b0;
		model_mem[addr] = data;
		// read data follows a write to the registered read address
		if (model_mem.exists(last_rd_addr))
		begin
			check_value("rd_data_o", rd_data_o, model_mem[last_rd_addr]);
		end
	endtask

	task automatic read_weight(input logic [15:0] addr, input logic [15:0] expected);
		rd_en_i   = 1'b1;
		rd_addr_i = addr;
		@(posedge clk_i);
		#2;
		rd_en_i = 1'b0;
		last_rd_addr = addr;
		check_value("rd_data_o", rd_data_o, expected);
		model_push(addr);
	endtask

	task automatic pop_entry(input logic exp_valid);
		logic [31:0] entry;
		pop_i = 1'b1;
		@(posedge clk_i);
		#2;
		pop_i = 1'b0;
		check_value("pop_valid_o", pop_valid_o, exp_valid);
		if (exp_valid && model_q.size() == 0)
		begin
			errors++;
			$display("a pop at %0t ns expects data but the model queue is empty", $time);
		end
		else if (exp_valid)
		begin
			entry = model_q.pop_front();
			check_value("pop_weight_o", pop_weight_o, entry[31:16]);
			check_value("pop_nurn_o", pop_nurn_o, entry[15:8]);
			check_value("pop_axon_o", pop_axon_o, entry[7:0]);
		end
	endtask

	task automatic start_step();
		start_i = 1'b1;
		@(posedge clk_i);
		#2;
		start_i = 1'b0;
		model_q.delete();
	endtask

	// random reads within four addresses above the base
	task automatic fill_reads(input logic [15:0] base, input logic [15:0] count);
		logic [15:0] addr;
		for (int k = 0; k < count; k++)
		begin
			addr = base + 16'($random(seed) & 3);
			read_weight(addr, model_weight(addr));
		end
	endtask

	task automatic run_case(input int i);
		case (case_op[i])
			"W": write_weight(case_addr[i], case_data[i]);
			"R": read_weight(case_addr[i], case_exp[i]);
			"S": start_step();
			"F": fill_reads(case_addr[i], case_data[i]);
			"P":
			begin
				repeat (case_data[i])
				begin
					pop_entry(case_exp[i][0]);
				end
			end
			"L":
			begin
				check_value("fifo_level_o", fifo_level_o, case_exp[i]);
				check_value("fifo_level_o vs model", fifo_level_o, model_q.size());
				check_value("overflow_o", overflow_o, case_data[i][0]);
			end
			default:
			begin
				errors++;
				$display("unknown operation %c in case line %0d", case_op[i], i);
			end
		endcase
		// idle edge lets a pending push land
		@(posedge clk_i);
		#2;
	endtask

	always @(posedge clk_i)
	begin
		cycle_count++;
		if (cycle_count > cycle_limit)
		begin
			$display("timeout: the run went past %0d cycles", cycle_limit);
			$display("checks: %0d, errors: %0d", checks, errors + 1);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	initial
	begin
		rst_n_i      = 1'b0;
		start_i      = 1'b0;
		wr_en_i      = 1'b0;
		wr_addr_i    = '0;
		wr_data_i    = '0;
		rd_en_i      = 1'b0;
		rd_addr_i    = '0;
		pop_i        = 1'b0;
		last_rd_addr = '0;
		seed         = 27803;
		errors       = 0;
		checks       = 0;
		cycle_count  = 0;
		load_cases();
		// 8 cycles per line, one per repeated read or pop, and margin
		cycle_limit = 600;
		for (int i = 0; i < case_op.size(); i++)
		begin
			cycle_limit += 8;
			if (case_op[i] == "F" || case_op[i] == "P")
			begin
				cycle_limit += case_data[i];
			end
		end
		repeat (2) @(posedge clk_i);
		#2;
		rst_n_i = 1'b1;
		@(posedge clk_i);
		#2;
		for (int i = 0; i < case_op.size(); i++)
		begin
			run_case(i);
		end
		total_errors = errors + uut.u_fifo.u_assertions.fail_count;
		$display("checks: %0d, check errors: %0d, assertion failures: %0d",
			checks, errors, uut.u_fifo.u_assertions.fail_count);
		if (total_errors == 0)
		begin
			$display("NO ERRORS");
		end
		else
		begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// ==== testbench/weight_cases.txt ====
# op addr data expected, hex; W write, R read (expected = rd_data), S start
# P: data = pop count, expected = valid; L: data = overflow, expected = level; F: addr = base, data = reads
W 0102 1234 0000
R 0102 0000 1234
W 0102 abcd 0000
P 0000 0001 0001
W 0305 0011 0000
W 0306 0022 0000
W 0307 0033 0000
W 0308 0044 0000
R 0307 0000 0033
R 0305 0000 0011
L 0000 0000 0002
P 0000 0002 0001
P 0000 0001 0000
L 0000 0000 0000
F 0305 0208 0000
L 0000 0001 0200
P 0000 0200 0001
R 0308 0000 0044
R 0306 0000 0022
L 0000 0001 0002
S 0000 0000 0000
L 0000 0000 0000
P 0000 0001 0000
R 0306 0000 0022
P 0000 0001 0001
L 0000 0000 0000

// ==== vlog.f ====
+incdir+include
src/synapse_pkg.sv
src/queue_pkg.sv
src/weight_fifo_if.sv
src/weight_store.sv
src/weight_fifo.sv
src/weight_drain.sv
src/synapse_mem_top.sv
testbench/synapse_mem_assertions.sv
testbench/tb_synapse_mem.sv
